/* hw/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// first fetch address out of reset
`define CORE_RESET_VECTOR 32'h8000_0000

// byte step between consecutive instruction words
`define CORE_PC_INCREMENT 32'd4

// architectural integer registers including x0
`define CORE_NUM_REGS 32

// sequencer phases per instruction
`define CORE_NUM_PHASES 3

// rd is written and the retire trace fires in this phase
`define CORE_WB_PHASE 2'd1

// the edge closing this phase moves pc on by one word
`define CORE_PC_PHASE 2'd2

`endif

/* hw/core_pkg.sv */
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes the core executes
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,  // addi slti xori ori andi slli srli
    OP_REG = 7'b0110011   // add sub sll slt xor srl or and
  } opcode_e;

  // funct3 values shared by the register and immediate forms
  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_SLL = 3'b001,
    F3_SLT = 3'b010,
    F3_XOR = 3'b100,
    F3_SR  = 3'b101,  // srl/sra picked by funct7[5]
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } funct3_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  // R-type field layout, also valid for the I-type low fields
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } inst_fmt_t;

  typedef struct packed {
    alu_op_e  alu_op;
    logic     src2_is_imm;
    logic     wr_en;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

endpackage

/* hw/fetch_sequencer.sv */
`include "core_macros.svh"

module fetch_sequencer import core_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output logic  wb_phase,
  output logic  pc_phase,
  output word_t pc
);

  localparam logic [1:0] last_phase = 2'(`CORE_NUM_PHASES - 1);

  logic [1:0] phase;  // 0 present, 1 write back, 2 pc step

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= 2'd0;
    end else if (phase == last_phase) begin
      phase <= 2'd0;
    end else begin
      phase <= phase + 2'd1;
    end
  end

  assign wb_phase = (phase == `CORE_WB_PHASE);
  assign pc_phase = (phase == `CORE_PC_PHASE);

  // pc holds for all three phases
  // so the instruction word stays put until the write is done
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `CORE_RESET_VECTOR;
    end else if (pc_phase) begin
      pc <= pc + `CORE_PC_INCREMENT;
    end
  end

endmodule

/* hw/decode_unit.sv */
module decode_unit import core_pkg::*; (
  input  word_t inst,
  output ctrl_t ctrl
);

  inst_fmt_t fields;
  word_t     imm_i;     // sign extended inst[31:20]
  word_t     shamt;     // zero extended inst[24:20]
  logic      is_reg;
  logic      is_imm;
  logic      is_shift;
  logic      alt;       // funct7[5]
  logic      legal;
  alu_op_e   alu_op;

  assign fields = inst_fmt_t'(inst);

  assign is_reg = (fields.opcode == OP_REG);
  assign is_imm = (fields.opcode == OP_IMM);
  assign alt    = fields.funct7[5];

  assign is_shift = (fields.funct3 == F3_SLL) || (fields.funct3 == F3_SR);

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign shamt = {27'd0, fields.rs2};

  // funct3 picks the operation for both formats
  // funct7[5] only matters for sub and the right shift
  always_comb begin
    alu_op = ALU_ADD;
    legal  = 1'b1;
    case (fields.funct3)
      F3_ADD: begin
        if (is_reg && alt) begin
          alu_op = ALU_SUB;
        end else begin
          alu_op = ALU_ADD;  // addi ignores funct7, those are imm bits
        end
      end
      F3_SLL: begin
        alu_op = ALU_SLL;
      end
      F3_SLT: begin
        alu_op = ALU_SLT;
      end
      F3_XOR: begin
        alu_op = ALU_XOR;
      end
      F3_SR: begin
        alu_op = ALU_SRL;
        legal  = !alt;  // sra/srai not implemented
      end
      F3_OR: begin
        alu_op = ALU_OR;
      end
      F3_AND: begin
        alu_op = ALU_AND;
      end
      default: begin
        legal = 1'b0;  // sltu/sltiu
      end
    endcase
  end

  always_comb begin
    ctrl             = '0;
    ctrl.alu_op      = alu_op;
    ctrl.src2_is_imm = is_imm;
    ctrl.rd          = fields.rd;
    ctrl.rs1         = fields.rs1;
    ctrl.rs2         = fields.rs2;
    ctrl.imm         = is_shift ? shamt : imm_i;
    // anything else turns into a no-op
    ctrl.wr_en       = (is_reg || is_imm) && legal;
  end

endmodule

/* hw/reg_file.sv */
`include "core_macros.svh"

module reg_file import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wb_phase,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     wr_en,
  input  word_t    wdata,
  output word_t    src1,
  output word_t    src2
);

  word_t regs [`CORE_NUM_REGS];
  logic  wr_fire;

  // one write per instruction, x0 never written
  assign wr_fire = wb_phase && wr_en && (rd != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire) begin
      regs[rd] <= wdata;
    end
  end

  // combinational read ports
  assign src1 = (rs1 == '0) ? '0 : regs[rs1];
  assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/execute_unit.sv */
module execute_unit import core_pkg::*; (
  input  word_t   src1,
  input  word_t   src2,
  input  word_t   imm,
  input  alu_op_e alu_op,
  input  logic    src2_is_imm,
  output word_t   result
);

  word_t      op2;
  logic [4:0] shamt;
  logic       lt_signed;

  // rs2 value or immediate as second operand
  assign op2 = src2_is_imm ? imm : src2;

  assign shamt     = op2[4:0];
  assign lt_signed = ($signed(src1) < $signed(op2));

  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        result = src1 + op2;
      end
      ALU_SUB: begin
        result = src1 - op2;
      end
      ALU_AND: begin
        result = src1 & op2;
      end
      ALU_OR: begin
        result = src1 | op2;
      end
      ALU_XOR: begin
        result = src1 ^ op2;
      end
      ALU_SLT: begin
        result = {31'd0, lt_signed};
      end
      ALU_SLL: begin
        result = src1 << shamt;
      end
      ALU_SRL: begin
        result = src1 >> shamt;  // logical, zero fill
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* hw/core_top.sv */
module core_top import core_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  word_t   inst,
  output word_t   pc,
  output retire_t retire
);

  logic  wb_phase;
  ctrl_t ctrl;
  word_t src1;
  word_t src2;
  word_t result;

  fetch_sequencer u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_phase (wb_phase),
    .pc_phase (),
    .pc       (pc)
  );

  // inst is read straight off the bus while pc is held
  decode_unit u_dec (
    .inst (inst),
    .ctrl (ctrl)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_phase (wb_phase),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .wr_en    (ctrl.wr_en),
    .wdata    (result),
    .src1     (src1),
    .src2     (src2)
  );

  execute_unit u_exe (
    .src1        (src1),
    .src2        (src2),
    .imm         (ctrl.imm),
    .alu_op      (ctrl.alu_op),
    .src2_is_imm (ctrl.src2_is_imm),
    .result      (result)
  );

  // trace mirrors the register write, x0 writes included
  assign retire.valid = wb_phase && ctrl.wr_en;
  assign retire.rd    = ctrl.rd;
  assign retire.data  = result;

endmodule

/* dv/core_assert.sv */
`include "core_macros.svh"

module core_assert import core_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input word_t   pc,
  input retire_t retire
);

  // first cycle out of reset
  property p_reset_state;
    @(posedge clk) $rose(rst_n) |-> (pc == `CORE_RESET_VECTOR) && !retire.valid;
  endproperty

  // pc only ever steps forward one word
  property p_pc_step;
    @(posedge clk) disable iff (!rst_n)
      (pc != $past(pc)) |-> (pc == $past(pc) + `CORE_PC_INCREMENT);
  endproperty

  property p_first_step;
    @(posedge clk)
      $rose(rst_n) |=> (pc == $past(pc)) ##1 (pc == $past(pc)) ##1 (pc != $past(pc));
  endproperty

  // three cycles per instruction
  property p_pc_period;
    @(posedge clk) disable iff (!rst_n)
      (pc != $past(pc)) |=> (pc == $past(pc)) ##1 (pc == $past(pc)) ##1 (pc != $past(pc));
  endproperty

  property p_retire_pulse;
    @(posedge clk) disable iff (!rst_n)
      retire.valid |=> !retire.valid;
  endproperty

  a_reset_state: assert property (p_reset_state)
    else $error("pc or retire not in reset state after reset release");
  a_pc_step: assert property (p_pc_step)
    else $error("pc changed by something other than one word");
  a_first_step: assert property (p_first_step)
    else $error("first pc change not three cycles after reset release");
  a_pc_period: assert property (p_pc_period)
    else $error("pc changes not three cycles apart");
  a_retire_pulse: assert property (p_retire_pulse)
    else $error("retire valid high in two consecutive cycles");

endmodule

/* dv/core_tb.sv */
`include "core_macros.svh"

module core_tb import core_pkg::*; ();

  localparam int half_period = 10;
  localparam int clk_period  = 2 * half_period;
  localparam int n_random    = 300;
  localparam int n_directed  = 80;  // upper bound, flush slots included
  localparam int timeout     = (n_random + n_directed) * 3 * clk_period * 2
                               + 10 * clk_period;

  logic    clk;
  logic    rst_n;
  word_t   inst;
  word_t   pc;
  retire_t retire;

  logic [1:0] phase;      // mirror of the core's sequencer
  logic       exp_valid;
  reg_idx_t   exp_rd;
  word_t      exp_data;
  word_t      shadow [`CORE_NUM_REGS];

  int    errors;
  int    checks;
  int    n_tests;
  int    n_failed;
  int    errors_at_start;
  string test_name;

  initial clk = 1'b0;
  always #(half_period) clk = ~clk;

  core_top u_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .inst   (inst),
    .pc     (pc),
    .retire (retire)
  );

  bind core_top core_assert u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .pc     (pc),
    .retire (retire)
  );

  // 0 present, 1 write back, 2 pc step
  always @(posedge clk) begin
    if (!rst_n) begin
      phase <= 2'd0;
    end else begin
      phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
    end
  end

  // retire trace against the shadow model
  always @(posedge clk) begin
    if (rst_n) begin
      checks++;
      if (phase == `CORE_WB_PHASE) begin
        assert (retire.valid == exp_valid) else begin
          $display("FAIL @%0t: retire.valid %0b, expected %0b", $time, retire.valid, exp_valid);
          errors++;
        end
        if (exp_valid) begin
          assert (retire.rd == exp_rd && retire.data == exp_data) else begin
            $display("FAIL @%0t: retire rd %0d data %h, expected rd %0d data %h",
                     $time, retire.rd, retire.data, exp_rd, exp_data);
            errors++;
          end
        end
      end else begin
        assert (!retire.valid) else begin
          $display("FAIL @%0t: retire.valid high outside write back phase", $time);
          errors++;
        end
      end
    end
  end

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    word_t r;
    case (op)
      ALU_ADD: r = a + b;
      ALU_SUB: r = a - b;
      ALU_AND: r = a & b;
      ALU_OR:  r = a | b;
      ALU_XOR: r = a ^ b;
      ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLL: r = a << b[4:0];
      ALU_SRL: r = a >> b[4:0];
      default: r = '0;
    endcase
    return r;
  endfunction

  // RV32I funct3 encodings
  function automatic logic [2:0] funct3_of(input alu_op_e op);
    logic [2:0] f3;
    case (op)
      ALU_SLL: f3 = 3'b001;
      ALU_SLT: f3 = 3'b010;
      ALU_XOR: f3 = 3'b100;
      ALU_SRL: f3 = 3'b101;
      ALU_OR:  f3 = 3'b110;
      ALU_AND: f3 = 3'b111;
      default: f3 = 3'b000;  // add and sub
    endcase
    return f3;
  endfunction

  // new word goes out on the edge that moves pc
  task automatic issue(input word_t word, input logic valid, input reg_idx_t rd,
                       input word_t data);
    do begin
      @(posedge clk);
    end while (phase != `CORE_PC_PHASE);
    inst      <= word;
    exp_valid <= valid;
    exp_rd    <= rd;
    exp_data  <= data;
  endtask

  task automatic exec_r(input alu_op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                        input reg_idx_t rs2);
    logic [6:0] f7;
    word_t      w;
    word_t      d;
    f7 = (op == ALU_SUB) ? 7'b0100000 : 7'b0000000;
    w  = {f7, rs2, rs1, funct3_of(op), rd, 7'b0110011};
    d  = alu_model(op, shadow[rs1], shadow[rs2]);
    if (rd != 5'd0) begin
      shadow[rd] = d;
    end
    issue(w, 1'b1, rd, d);
  endtask

  task automatic exec_i(input alu_op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                        input logic [11:0] imm);
    word_t w;
    word_t d;
    w = {imm, rs1, funct3_of(op), rd, 7'b0010011};
    d = alu_model(op, shadow[rs1], {{20{imm[11]}}, imm});
    if (rd != 5'd0) begin
      shadow[rd] = d;
    end
    issue(w, 1'b1, rd, d);
  endtask

  task automatic exec_bad(input word_t w);
    issue(w, 1'b0, 5'd0, 32'd0);  // no retire expected
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    int n;
    exec_bad(32'h0000_0000);  // flush slot, last retire is checked by now
    n = errors - errors_at_start;
    n_tests++;
    if (n == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, n);
      n_failed++;
    end
  endtask

  task automatic random_program(input int count);
    alu_op_e  i_ops [5] = '{ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT};
    int       kind;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    w;
    for (int i = 0; i < count; i++) begin
      kind = int'($urandom_range(0, 9));
      rd   = 5'($urandom_range(0, 15));  // small range keeps dependencies dense
      rs1  = 5'($urandom_range(0, 15));
      rs2  = 5'($urandom_range(0, 15));
      if (kind == 0) begin
        w = $urandom;
        if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011) begin
          w[6:0] = 7'b1100011;
        end
        exec_bad(w);
      end else if (kind < 6) begin
        exec_r(alu_op_e'(4'($urandom_range(0, 7))), rd, rs1, rs2);
      end else begin
        exec_i(i_ops[$urandom_range(0, 4)], rd, rs1, 12'($urandom));
      end
    end
  endtask

  initial begin
    #(timeout);
    $display("timeout: run did not finish within %0d time units", timeout);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(32'h767a));
    rst_n     <= 1'b0;
    inst      <= '0;
    exp_valid <= 1'b0;
    exp_rd    <= '0;
    exp_data  <= '0;
    errors    = 0;
    checks    = 0;
    n_tests   = 0;
    n_failed  = 0;
    for (int i = 0; i < `CORE_NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    begin_test("reset");
    @(posedge clk);
    assert (pc == `CORE_RESET_VECTOR && !retire.valid) else begin
      $display("FAIL @%0t: pc %h after reset, retire.valid %0b", $time, pc, retire.valid);
      errors++;
    end
    end_test();

    begin_test("r_type");
    exec_i(ALU_ADD, 5'd1, 5'd0, 12'hffb);  // x1 = -5
    exec_i(ALU_ADD, 5'd2, 5'd0, 12'd7);
    exec_r(ALU_ADD, 5'd3, 5'd1, 5'd2);
    exec_r(ALU_SUB, 5'd4, 5'd2, 5'd1);
    exec_r(ALU_SUB, 5'd5, 5'd1, 5'd2);
    exec_r(ALU_SLT, 5'd6, 5'd1, 5'd2);  // negative below positive
    exec_r(ALU_SLT, 5'd7, 5'd2, 5'd1);
    exec_r(ALU_AND, 5'd8, 5'd1, 5'd2);
    exec_r(ALU_OR, 5'd9, 5'd1, 5'd2);
    exec_r(ALU_XOR, 5'd10, 5'd1, 5'd2);
    exec_r(ALU_SLL, 5'd11, 5'd2, 5'd2);
    exec_r(ALU_SRL, 5'd12, 5'd1, 5'd2);   // zero fill from the top
    exec_i(ALU_ADD, 5'd13, 5'd0, 12'd35);
    exec_r(ALU_SLL, 5'd14, 5'd2, 5'd13);  // only the low 5 bits count
    end_test();

    begin_test("i_type");
    exec_i(ALU_ADD, 5'd15, 5'd1, 12'hf9c);
    exec_i(ALU_AND, 5'd16, 5'd1, 12'hff0);
    exec_i(ALU_OR, 5'd17, 5'd2, 12'hf00);
    exec_i(ALU_XOR, 5'd18, 5'd1, 12'hfff);
    exec_i(ALU_SLT, 5'd19, 5'd1, 12'hffd);
    exec_i(ALU_SLT, 5'd20, 5'd2, 12'hfff);
    exec_i(ALU_ADD, 5'd21, 5'd21, 12'h800);  // most negative immediate
    end_test();

    begin_test("x0_invalid");
    exec_i(ALU_ADD, 5'd0, 5'd2, 12'd123);  // retires with rd 0
    exec_r(ALU_ADD, 5'd22, 5'd0, 5'd2);
    exec_r(ALU_OR, 5'd0, 5'd1, 5'd2);
    exec_r(ALU_ADD, 5'd23, 5'd2, 5'd0);
    exec_bad(32'hffff_ffff);
    exec_bad(32'h0000_2003);  // load
    exec_bad(32'h0000_0063);  // branch
    end_test();

    begin_test("raw_chain");
    exec_i(ALU_ADD, 5'd24, 5'd0, 12'd1);
    for (int i = 0; i < 6; i++) begin
      exec_r(ALU_ADD, 5'd24, 5'd24, 5'd24);
      exec_r(ALU_XOR, 5'd25, 5'd25, 5'd24);
      exec_i(ALU_ADD, 5'd25, 5'd25, 12'hffe);
    end
    exec_r(ALU_SUB, 5'd26, 5'd25, 5'd24);
    end_test();

    begin_test("random");
    random_program(n_random);
    end_test();

    repeat (3) @(posedge clk);
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hw
hw/core_pkg.sv
hw/fetch_sequencer.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/core_top.sv
dv/core_assert.sv
dv/core_tb.sv

/* Makefile */
TOP := core_tb

.PHONY: all lint build sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
